// File: rvDecodePkg.sv
package rvDecodePkg;

    // datapath and register file sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // instruction field widths
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int IMM_BITS_W = 25;

    // major opcodes, RV32I base set
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;

    // funct3 of the arithmetic ops
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // load/store access size, funct3 of the memory ops
    localparam logic [FUNCT3_W-1:0] MEM_B  = 3'b000;
    localparam logic [FUNCT3_W-1:0] MEM_H  = 3'b001;
    localparam logic [FUNCT3_W-1:0] MEM_W  = 3'b010;
    localparam logic [FUNCT3_W-1:0] MEM_BU = 3'b100;
    localparam logic [FUNCT3_W-1:0] MEM_HU = 3'b101;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASSB = 4'd10
    } aluCtrlE;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immSrcE;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrcE;

    // funct3 of a load or store, zero for everything else
    typedef logic [2:0] memAccessT;

    // execute-stage controls, all zero is a bubble
    typedef struct packed {
        logic      regWrite;
        logic      memWrite;
        logic      jump;
        logic      branch;
        logic      jalr;
        logic      aluSrc;
        logic      illegal;
        resultSrcE resultSrc;
        aluCtrlE   aluControl;
        memAccessT memAccess;
    } ctrlT;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pcPlus4;
    } decodeInT;

    typedef struct packed {
        logic                  en;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wbPortT;

    typedef struct packed {
        ctrlT                  ctrl;
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pcPlus4;
        logic [XLEN-1:0]       extImm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
    } idExT;

endpackage

// File: controlUnit.sv
`timescale 1ns/10ps

module controlUnit import rvDecodePkg::*; (
    input  logic [OPCODE_W-1:0] opcode,
    input  logic [FUNCT3_W-1:0] funct3,
    input  logic                funct7b5,
    output ctrlT                ctrl,
    output immSrcE              immSrc
);

    logic    isReg;
    logic    loadOk;
    logic    storeOk;
    aluCtrlE aluArith;

    assign isReg = (opcode == OP_REG);

    // legal access sizes
    always_comb begin
        case (funct3)
            MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU: loadOk = 1'b1;
            default:                             loadOk = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            MEM_B, MEM_H, MEM_W: storeOk = 1'b1;
            default:             storeOk = 1'b0;
        endcase
    end

    // alu sub-decoder for register and immediate arithmetic
    always_comb begin
        case (funct3)
            F3_ADD_SUB: aluArith = (isReg && funct7b5) ? ALU_SUB : ALU_ADD;
            F3_SLL:     aluArith = ALU_SLL;
            F3_SLT:     aluArith = ALU_SLT;
            F3_SLTU:    aluArith = ALU_SLTU;
            F3_XOR:     aluArith = ALU_XOR;
            // funct7 bit 5 picks arithmetic shift in both formats
            F3_SRL_SRA: aluArith = funct7b5 ? ALU_SRA : ALU_SRL;
            F3_OR:      aluArith = ALU_OR;
            F3_AND:     aluArith = ALU_AND;
            default:    aluArith = ALU_ADD;
        endcase
    end

    // main decoder
    always_comb begin
        ctrl   = '0;
        immSrc = IMM_I;
        case (opcode)
            OP_LOAD: begin
                if (loadOk) begin
                    ctrl.regWrite   = 1'b1;
                    ctrl.aluSrc     = 1'b1;
                    ctrl.resultSrc  = RES_MEM;
                    ctrl.aluControl = ALU_ADD;
                    ctrl.memAccess  = funct3;
                end else begin
                    ctrl.illegal = 1'b1;
                end
                immSrc = IMM_I;
            end
            OP_STORE: begin
                if (storeOk) begin
                    ctrl.memWrite   = 1'b1;
                    ctrl.aluSrc     = 1'b1;
                    ctrl.aluControl = ALU_ADD;
                    ctrl.memAccess  = funct3;
                end else begin
                    ctrl.illegal = 1'b1;
                end
                immSrc = IMM_S;
            end
            OP_BRANCH: begin
                // compare by subtraction
                ctrl.branch     = 1'b1;
                ctrl.aluControl = ALU_SUB;
                immSrc          = IMM_B;
            end
            OP_JAL: begin
                ctrl.regWrite   = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.resultSrc  = RES_PC4;
                ctrl.aluControl = ALU_ADD;
                immSrc          = IMM_J;
            end
            OP_JALR: begin
                // jalr marks the rs1-relative target
                ctrl.regWrite   = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.jalr       = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.resultSrc  = RES_PC4;
                ctrl.aluControl = ALU_ADD;
                immSrc          = IMM_I;
            end
            OP_IMM: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = aluArith;
                immSrc          = IMM_I;
            end
            OP_REG: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluControl = aluArith;
            end
            OP_LUI: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = ALU_PASSB;
                immSrc          = IMM_U;
            end
            OP_AUIPC: begin
                ctrl.regWrite   = 1'b1;
                ctrl.aluSrc     = 1'b1;
                ctrl.aluControl = ALU_ADD;
                immSrc          = IMM_U;
            end
            default: begin
                // system, fence and unknown opcodes
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: registerFile.sv
`timescale 1ns/10ps

module registerFile import rvDecodePkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [REG_ADDR_W-1:0] rdAddr1,
    input  logic [REG_ADDR_W-1:0] rdAddr2,
    input  wbPortT                wb,
    output logic [XLEN-1:0]       rdData1,
    output logic [XLEN-1:0]       rdData2
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // read with bypass from the writeback port
    function automatic logic [XLEN-1:0] readPort(
        input logic [REG_ADDR_W-1:0] addr,
        input wbPortT                wr,
        input logic [XLEN-1:0]       stored
    );
        logic [XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (wr.en && (wr.addr == addr)) begin
            value = wr.data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    always_comb begin
        rdData1 = readPort(rdAddr1, wb, (rdAddr1 == '0) ? '0 : regs[rdAddr1]);
        rdData2 = readPort(rdAddr2, wb, (rdAddr2 == '0) ? '0 : regs[rdAddr2]);
    end

endmodule

// File: immExtend.sv
`timescale 1ns/10ps

module immExtend import rvDecodePkg::*; (
    input  logic [IMM_BITS_W-1:0] immBits,
    input  immSrcE                immSrc,
    output logic [XLEN-1:0]       extImm
);

    // immBits[n] is instruction bit n+7
    logic sign;

    assign sign = immBits[24];

    always_comb begin
        case (immSrc)
            IMM_I: begin
                extImm = {{20{sign}}, immBits[24:13]};
            end
            IMM_S: begin
                extImm = {{20{sign}}, immBits[24:18], immBits[4:0]};
            end
            IMM_B: begin
                extImm = {{20{sign}}, immBits[0], immBits[23:18], immBits[4:1], 1'b0};
            end
            // upper 20 bits, low half zero
            IMM_U: begin
                extImm = {immBits[24:5], 12'b0};
            end
            IMM_J: begin
                extImm = {{12{sign}}, immBits[12:5], immBits[13], immBits[23:14], 1'b0};
            end
            default: begin
                extImm = '0;
            end
        endcase
    end

endmodule

// File: decodeStage.sv
`timescale 1ns/10ps

module decodeStage import rvDecodePkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     flush,
    input  decodeInT fetched,
    input  wbPortT   wb,
    output idExT     idEx
);

    logic [XLEN-1:0]       instr;
    logic [OPCODE_W-1:0]   opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic                  funct7b5;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;

    ctrlT            ctrlD;
    immSrcE          immSrcD;
    logic [XLEN-1:0] rd1D;
    logic [XLEN-1:0] rd2D;
    logic [XLEN-1:0] extImmD;
    idExT            idExNext;

    // instruction fields
    assign instr    = fetched.instr;
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];

    controlUnit controlUnit_inst (
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .ctrl     (ctrlD),
        .immSrc   (immSrcD)
    );

    registerFile registerFile_inst (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddr1 (rs1),
        .rdAddr2 (rs2),
        .wb      (wb),
        .rdData1 (rd1D),
        .rdData2 (rd2D)
    );

    immExtend immExtend_inst (
        .immBits (instr[31:7]),
        .immSrc  (immSrcD),
        .extImm  (extImmD)
    );

    // next ID/EX value, flush turns it into a bubble
    always_comb begin
        idExNext.ctrl    = flush ? ctrlT'('0) : ctrlD;
        idExNext.rd1     = rd1D;
        idExNext.rd2     = rd2D;
        idExNext.pc      = fetched.pc;
        idExNext.pcPlus4 = fetched.pcPlus4;
        idExNext.extImm  = extImmD;
        idExNext.rs1     = rs1;
        idExNext.rs2     = rs2;
        idExNext.rd      = rd;
    end

    // ID/EX register, flush overrides stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else if (flush || !stall) begin
            idEx <= idExNext;
        end
    end

endmodule

// File: tbDecodeStage.sv
`timescale 1ns/10ps

module tbDecodeStage import rvDecodePkg::*; ();

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 5;
    localparam int READ_CYCLES   = 60;
    localparam int BYPASS_CYCLES = 30;
    localparam int CTRL_CYCLES   = 300;
    localparam int HAZARD_CYCLES = 150;
    localparam int TEST_CYCLES   = RESET_CYCLES + NUM_REGS + READ_CYCLES + BYPASS_CYCLES
                                 + CTRL_CYCLES + HAZARD_CYCLES + 10;
    // half again plus some slack
    localparam int CYCLE_LIMIT   = TEST_CYCLES * 3 / 2 + 100;

    logic     clk;
    logic     arstN;
    logic     stall;
    logic     flush;
    decodeInT fetched;
    wbPortT   wb;
    idExT     idEx;

    idExT            expIdEx;
    logic [XLEN-1:0] modelRegs [NUM_REGS];
    int              cycleCount = 0;

    decodeStage decodeStage_inst (
        .clk     (clk),
        .arstN   (arstN),
        .stall   (stall),
        .flush   (flush),
        .fetched (fetched),
        .wb      (wb),
        .idEx    (idEx)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic reportMismatch(input string name, input logic [191:0] expected,
                                  input logic [191:0] actual);
        $display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, name, expected, actual);
        $display("Testbench failed");
        $fatal(1, "wrong value on %s", name);
    endtask

    // RV32I arithmetic decode with alt as funct7 bit 5
    function automatic aluCtrlE refAlu(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic ctrlT refCtrl(input logic [31:0] ins);
        ctrlT       c;
        logic [6:0] op;
        logic [2:0] f3;
        op = ins[6:0];
        f3 = ins[14:12];
        c  = '0;
        if (op == OP_LOAD && (f3 == 3'b011 || f3[2:1] == 2'b11)) begin
            c.illegal = 1'b1;
        end else if (op == OP_STORE && f3 > 3'b010) begin
            c.illegal = 1'b1;
        end else if (op == OP_LOAD || op == OP_STORE) begin
            c.regWrite  = (op == OP_LOAD);
            c.memWrite  = (op == OP_STORE);
            c.aluSrc    = 1'b1;
            c.resultSrc = (op == OP_LOAD) ? RES_MEM : RES_ALU;
            c.memAccess = f3;
        end else if (op == OP_BRANCH) begin
            c.branch     = 1'b1;
            c.aluControl = ALU_SUB;
        end else if (op == OP_JAL || op == OP_JALR) begin
            c.regWrite  = 1'b1;
            c.jump      = 1'b1;
            c.jalr      = (op == OP_JALR);
            c.aluSrc    = (op == OP_JALR);
            c.resultSrc = RES_PC4;
        end else if (op == OP_IMM || op == OP_REG) begin
            c.regWrite   = 1'b1;
            c.aluSrc     = (op == OP_IMM);
            c.aluControl = refAlu(f3, ins[30] && (op == OP_REG || f3 == 3'b101));
        end else if (op == OP_LUI || op == OP_AUIPC) begin
            c.regWrite   = 1'b1;
            c.aluSrc     = 1'b1;
            c.aluControl = (op == OP_LUI) ? ALU_PASSB : ALU_ADD;
        end else begin
            c.illegal = 1'b1;
        end
        return c;
    endfunction

    // immediate by format with R-type and illegal on the I layout
    function automatic logic [31:0] refImm(input logic [31:0] ins);
        case (ins[6:0])
            OP_STORE:         return 32'($signed({ins[31:25], ins[11:7]}));
            OP_BRANCH:        return 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            OP_LUI, OP_AUIPC: return {ins[31:12], 12'h000};
            OP_JAL:           return 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
            default:          return 32'($signed(ins[31:20]));
        endcase
    endfunction

    function automatic logic [31:0] modelRead(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end
        // same-cycle writeback is visible
        if (wb.en && wb.addr == addr) begin
            return wb.data;
        end
        return modelRegs[addr];
    endfunction

    function automatic idExT expectedNext();
        idExT        e;
        logic [31:0] ins;
        ins       = fetched.instr;
        e.ctrl    = flush ? ctrlT'('0) : refCtrl(ins);
        e.rd1     = modelRead(ins[19:15]);
        e.rd2     = modelRead(ins[24:20]);
        e.pc      = fetched.pc;
        e.pcPlus4 = fetched.pcPlus4;
        e.extImm  = refImm(ins);
        e.rs1     = ins[19:15];
        e.rs2     = ins[24:20];
        e.rd      = ins[11:7];
        return e;
    endfunction

    // reference pipeline register and register file
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expIdEx <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                modelRegs[i] <= '0;
            end
        end else begin
            if (wb.en && wb.addr != 5'd0) begin
                modelRegs[wb.addr] <= wb.data;
            end
            if (flush || !stall) begin
                expIdEx <= expectedNext();
            end
        end
    end

    ctrlCheck: assert property (@(posedge clk) idEx.ctrl == expIdEx.ctrl)
        else reportMismatch("idEx.ctrl", 192'($sampled(expIdEx.ctrl)),
                            192'($sampled(idEx.ctrl)));
    rd1Check: assert property (@(posedge clk) idEx.rd1 == expIdEx.rd1)
        else reportMismatch("idEx.rd1", 192'($sampled(expIdEx.rd1)), 192'($sampled(idEx.rd1)));
    rd2Check: assert property (@(posedge clk) idEx.rd2 == expIdEx.rd2)
        else reportMismatch("idEx.rd2", 192'($sampled(expIdEx.rd2)), 192'($sampled(idEx.rd2)));
    pcCheck: assert property (@(posedge clk) idEx.pc == expIdEx.pc)
        else reportMismatch("idEx.pc", 192'($sampled(expIdEx.pc)), 192'($sampled(idEx.pc)));
    pcPlus4Check: assert property (@(posedge clk) idEx.pcPlus4 == expIdEx.pcPlus4)
        else reportMismatch("idEx.pcPlus4", 192'($sampled(expIdEx.pcPlus4)),
                            192'($sampled(idEx.pcPlus4)));
    immCheck: assert property (@(posedge clk) idEx.extImm == expIdEx.extImm)
        else reportMismatch("idEx.extImm", 192'($sampled(expIdEx.extImm)),
                            192'($sampled(idEx.extImm)));
    regAddrCheck: assert property (@(posedge clk)
        {idEx.rs1, idEx.rs2, idEx.rd} == {expIdEx.rs1, expIdEx.rs2, expIdEx.rd})
        else reportMismatch("idEx.rs1/rs2/rd",
                            192'($sampled({expIdEx.rs1, expIdEx.rs2, expIdEx.rd})),
                            192'($sampled({idEx.rs1, idEx.rs2, idEx.rd})));

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic presentInstr(input logic [31:0] ins);
        logic [31:0] pcVal;
        pcVal         = $urandom;
        pcVal[1:0]    = 2'b00;
        fetched.instr = ins;
        fetched.pc    = pcVal;
        fetched.pcPlus4 = pcVal + 32'd4;
    endtask

    function automatic logic [31:0] randomInstr(input logic [6:0] op);
        logic [31:0] r;
        r = $urandom;
        return {r[31:7], op};
    endfunction

    function automatic logic [6:0] randomOpcode();
        logic [31:0] pick;
        logic [31:0] r;
        pick = $urandom_range(0, 11);
        r    = $urandom;
        case (pick)
            0:       return OP_LOAD;
            1:       return OP_STORE;
            2:       return OP_BRANCH;
            3:       return OP_JAL;
            4:       return OP_JALR;
            5:       return OP_IMM;
            6:       return OP_REG;
            7:       return OP_LUI;
            8:       return OP_AUIPC;
            // system and fence
            9:       return 7'b1110011;
            10:      return 7'b0001111;
            default: return r[6:0];
        endcase
    endfunction

    initial begin
        logic [31:0] r;
        logic [31:0] ins;
        void'($urandom(32'h2f6822ae));
        clk     = 1'b0;
        arstN   = 1'b0;
        stall   = 1'b0;
        flush   = 1'b0;
        fetched = '0;
        wb      = '0;

        repeat (RESET_CYCLES) begin
            presentInstr(randomInstr(randomOpcode()));
            nextCycle();
            assert (idEx == '0) else reportMismatch("idEx in reset", '0, 192'(idEx));
        end
        arstN = 1'b1;
        assert (idEx == '0) else reportMismatch("idEx after reset", '0, 192'(idEx));

        // fill every register including x0
        for (int i = 0; i < NUM_REGS; i++) begin
            r  = $urandom;
            wb = '{en: 1'b1, addr: i[4:0], data: r};
            presentInstr(randomInstr(OP_REG));
            nextCycle();
        end
        wb.en = 1'b0;
        repeat (READ_CYCLES) begin
            presentInstr(randomInstr(OP_REG));
            nextCycle();
        end

        // x0 stays zero while being written
        r   = $urandom;
        wb  = '{en: 1'b1, addr: 5'd0, data: r};
        ins = randomInstr(OP_REG);
        ins[24:15] = '0;
        presentInstr(ins);
        nextCycle();

        for (int i = 0; i < BYPASS_CYCLES; i++) begin
            r   = $urandom;
            wb  = '{en: 1'b1, addr: r[4:0], data: $urandom};
            ins = randomInstr(OP_REG);
            ins[19:15] = r[4:0];
            if (i % 2 == 1) begin
                ins[24:20] = r[4:0];
            end
            presentInstr(ins);
            nextCycle();
        end

        repeat (CTRL_CYCLES) begin
            r  = $urandom;
            wb = '{en: r[0], addr: r[5:1], data: $urandom};
            presentInstr(randomInstr(randomOpcode()));
            nextCycle();
        end

        // random stall and flush with both together every tenth cycle
        for (int i = 0; i < HAZARD_CYCLES; i++) begin
            r     = $urandom;
            stall = r[0] || (i % 10 == 0);
            flush = (r[1] && r[2]) || (i % 10 == 0);
            wb    = '{en: r[3], addr: r[8:4], data: $urandom};
            if (!stall) begin
                presentInstr(randomInstr(randomOpcode()));
            end
            nextCycle();
        end

        stall = 1'b0;
        flush = 1'b0;
        wb.en = 1'b0;
        repeat (3) nextCycle();

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: rvDecode.f
rvDecodePkg.sv
controlUnit.sv
registerFile.sv
immExtend.sv
decodeStage.sv
tbDecodeStage.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tbDecodeStage
FILELIST = rvDecode.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
